/* common/stbuf_pkg.sv */
//------------------------------------------------
// store buffer shared definitions
// sizes, store size encoding and the structs
// passed between the pipeline stages
//------------------------------------------------
`default_nettype none

package stbuf_pkg;

   //------------------------------------------------
   // sizes
   //------------------------------------------------
   localparam int ADDR_W = 16;                 // byte address
   localparam int DATA_W = 32;
   localparam int BYTE_W = DATA_W / 8;         // bytes per word
   localparam int OFFS_W = $clog2(BYTE_W);     // byte offset bits
   localparam int DEPTH  = 4;                  // entries, power of two
   localparam int PTR_W  = $clog2(DEPTH);

   typedef logic [ADDR_W-1:OFFS_W] waddr_t;    // word address

   // store size as seen on the request
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   //------------------------------------------------
   // stage payloads
   //------------------------------------------------
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      size_e             size;
      logic [DATA_W-1:0] data;                 // right aligned
   } store_req_t;

   typedef struct packed {
      waddr_t            waddr;
      logic [BYTE_W-1:0] byteen;
      logic [DATA_W-1:0] data;                 // already in its lanes
   } lane_req_t;

   typedef struct packed {
      logic              valid;
      waddr_t            waddr;
      logic [BYTE_W-1:0] byteen;
      logic [DATA_W-1:0] data;
   } entry_t;

   typedef struct packed {
      logic [BYTE_W-1:0] byteen;               // bytes found in the buffer
      logic [DATA_W-1:0] data;
   } fwd_rsp_t;

endpackage

`default_nettype wire

/* stbuf/stbuf_capture.sv */
//------------------------------------------------
// store capture stage
// size decode, byte enables, lane alignment
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_capture
   import stbuf_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       store_valid,
   input  store_req_t store_req,
   input  logic       store_full,
   output logic       lane_valid,
   output lane_req_t  lane_req
);

   logic              xfer;
   logic [OFFS_W-1:0] offs;
   logic [BYTE_W-1:0] base_be;

   assign xfer = store_valid & ~store_full;   // store handshake
   assign offs = store_req.addr[OFFS_W-1:0];

   // enable pattern before the shift into place
   always_comb begin
      case (store_req.size)
         SZ_BYTE: base_be = BYTE_W'(1);
         SZ_HALF: base_be = BYTE_W'(3);
         SZ_WORD: base_be = '1;
         default: base_be = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lane_valid <= 1'b0;
      end else begin
         lane_valid <= xfer;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         lane_req.waddr  <= store_req.addr[ADDR_W-1:OFFS_W];
         lane_req.byteen <= base_be << offs;
         lane_req.data   <= store_req.data << {offs, 3'b000};   // 8 bits per lane
      end
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_entries.sv */
//------------------------------------------------
// store buffer entry array
// coalesce match, allocation, read and write
// pointers, occupancy for full and empty
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_entries
   import stbuf_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  lane_valid,
   input  lane_req_t             lane_req,
   input  logic                  drain_busy,
   input  logic                  pop,
   output entry_t [DEPTH-1:0]    entries,
   output entry_t                head,
   output logic [PTR_W-1:0]      wr_ptr,
   input  logic                  capture_busy,
   output logic                  store_full,
   output logic                  store_empty
);

   logic [DEPTH-1:0]  vld;
   waddr_t            addr_q [DEPTH];
   logic [BYTE_W-1:0] be_q   [DEPTH];
   logic [DATA_W-1:0] data_q [DEPTH];

   logic [PTR_W-1:0]  rd_ptr;
   logic [DEPTH-1:0]  match;
   logic [DEPTH-1:0]  wr_en;
   logic              coalesce;
   logic              alloc;
   logic [PTR_W:0]    num_vld;

   //------------------------------------------------
   // coalesce or allocate
   //------------------------------------------------
   // head on the bus is frozen, a store to it needs a new slot
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         match[i] = vld[i] && (addr_q[i] == lane_req.waddr) &&
                    !(drain_busy && (PTR_W'(i) == rd_ptr));
      end
   end

   assign coalesce = |match;
   assign alloc    = lane_valid & ~coalesce;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         wr_en[i] = lane_valid & (match[i] | (alloc & (PTR_W'(i) == wr_ptr)));
      end
   end

   // valid bits and pointers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld    <= '0;
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (wr_en[i]) begin
               vld[i] <= 1'b1;
            end else if (pop && (PTR_W'(i) == rd_ptr)) begin
               vld[i] <= 1'b0;                 // freed on ack
            end
         end
         if (alloc) wr_ptr <= wr_ptr + 1'b1;
         if (pop)   rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // entry payload, merged byte by byte
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en[i]) begin
            addr_q[i] <= lane_req.waddr;
            be_q[i]   <= (match[i] ? be_q[i] : '0) | lane_req.byteen;
            for (int b = 0; b < BYTE_W; b++) begin
               if (lane_req.byteen[b]) begin
                  data_q[i][8*b +: 8] <= lane_req.data[8*b +: 8];
               end
            end
         end
      end
   end

   //------------------------------------------------
   // outputs
   //------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         entries[i].valid  = vld[i];
         entries[i].waddr  = addr_q[i];
         entries[i].byteen = be_q[i];
         entries[i].data   = data_q[i];
      end
   end

   assign head = entries[rd_ptr];

   always_comb begin
      num_vld = '0;
      for (int i = 0; i < DEPTH; i++) begin
         num_vld = num_vld + {{PTR_W{1'b0}}, vld[i]};
      end
   end

   // counts the store still in capture, even if it would merge
   assign store_full  = (num_vld + {{PTR_W{1'b0}}, capture_busy}) >= (PTR_W+1)'(DEPTH);
   assign store_empty = (num_vld == '0);

endmodule

`default_nettype wire

/* stbuf/stbuf_fwd.sv */
//------------------------------------------------
// load forwarding from the entry array
// byte-wise merge, youngest entry wins
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_fwd
   import stbuf_pkg::*;
(
   input  waddr_t             load_addr,
   input  entry_t [DEPTH-1:0] entries,
   input  logic [PTR_W-1:0]   wr_ptr,
   output fwd_rsp_t           fwd
);

   logic [DEPTH-1:0] hit;
   logic [PTR_W-1:0] idx;

   // word hit per entry
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         hit[i] = entries[i].valid && (entries[i].waddr == load_addr);
      end
   end

   //------------------------------------------------
   // walk from oldest to youngest
   //------------------------------------------------
   // entry just below wr_ptr is the youngest, later passes overwrite
   always_comb begin
      fwd = '0;
      idx = '0;
      for (int k = DEPTH; k > 0; k--) begin
         idx = wr_ptr - PTR_W'(k);
         for (int b = 0; b < BYTE_W; b++) begin
            if (hit[idx] && entries[idx].byteen[b]) begin
               fwd.byteen[b]       = 1'b1;
               fwd.data[8*b +: 8]  = entries[idx].data[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_drain.sv */
//------------------------------------------------
// drain side, Wishbone classic master
// writes the head entry, pop on ack
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_drain
   import stbuf_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  entry_t            head,
   output logic              drain_busy,
   output logic              pop,
   output logic              wb_cyc,
   output logic              wb_stb,
   output logic              wb_we,
   output logic [ADDR_W-1:0] wb_adr,
   output logic [DATA_W-1:0] wb_dat_o,
   output logic [BYTE_W-1:0] wb_sel,
   input  logic              wb_ack
);

   typedef enum logic {IDLE, WRITE} state_e;

   state_e state;
   logic   start;

   assign start = (state == IDLE) && head.valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else if (start) begin
         state <= WRITE;
      end else if ((state == WRITE) && wb_ack) begin
         state <= IDLE;                       // at least one idle clock between cycles
      end
   end

   // head snapshot, held for the whole cycle
   always_ff @(posedge clk) begin
      if (start) begin
         wb_adr   <= {head.waddr, {OFFS_W{1'b0}}};
         wb_dat_o <= head.data;
         wb_sel   <= head.byteen;
      end
   end

   assign wb_cyc     = (state == WRITE);
   assign wb_stb     = (state == WRITE);
   assign wb_we      = (state == WRITE);
   assign pop        = (state == WRITE) && wb_ack;
   assign drain_busy = (state == WRITE) || start;   // head sampled or on the bus

endmodule

`default_nettype wire

/* source/stbuf_top.sv */
//------------------------------------------------
// store buffer top level
// capture, entries, forwarding and drain
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_top
   import stbuf_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // store side
   input  logic              store_valid,
   input  store_req_t        store_req,
   output logic              store_full,
   output logic              store_empty,
   // load lookup
   input  waddr_t            load_addr,
   output fwd_rsp_t          fwd,
   // Wishbone master
   output logic              wb_cyc,
   output logic              wb_stb,
   output logic              wb_we,
   output logic [ADDR_W-1:0] wb_adr,
   output logic [DATA_W-1:0] wb_dat_o,
   output logic [BYTE_W-1:0] wb_sel,
   input  logic              wb_ack
);

   logic               lane_valid;
   lane_req_t          lane_req;
   entry_t [DEPTH-1:0] entries;
   entry_t             head;
   logic [PTR_W-1:0]   wr_ptr;
   logic               drain_busy;
   logic               pop;

   stbuf_capture stbuf_capture_i (
      .clk, .rst_n, .store_valid, .store_req, .store_full,
      .lane_valid, .lane_req
   );

   stbuf_entries stbuf_entries_i (
      .clk, .rst_n, .lane_valid, .lane_req, .drain_busy, .pop,
      .entries, .head, .wr_ptr,
      .capture_busy (lane_valid),              // store in flight to the array
      .store_full, .store_empty
   );

   stbuf_fwd stbuf_fwd_i (.load_addr, .entries, .wr_ptr, .fwd);

   stbuf_drain stbuf_drain_i (
      .clk, .rst_n, .head, .drain_busy, .pop,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_sel, .wb_ack
   );

endmodule

`default_nettype wire

/* tests/stbuf_assert.sv */
//------------------------------------------------
// store buffer bound assertions
// alignment, Wishbone hold, empty versus full
// and bus activity
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_assert
   import stbuf_pkg::*;
(
   input logic              clk,
   input logic              rst_n,
   input logic              store_valid,
   input store_req_t        store_req,
   input logic              store_full,
   input logic              store_empty,
   input logic              wb_cyc,
   input logic              wb_stb,
   input logic              wb_ack,
   input logic [ADDR_W-1:0] wb_adr,
   input logic [DATA_W-1:0] wb_dat_o,
   input logic [BYTE_W-1:0] wb_sel
);

   logic aligned;

   assign aligned = (store_req.size == SZ_BYTE) ||
                    ((store_req.size == SZ_HALF) && !store_req.addr[0]) ||
                    ((store_req.size == SZ_WORD) && (store_req.addr[1:0] == 2'b00));

   a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      (store_valid && !store_full) |-> aligned)
      else $error("store accepted with a misaligned address");

   // request held until ack
   a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_sel)))
      else $error("Wishbone address, data or sel changed before ack");

   // empty buffer has no full flag and no write on the bus
   a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
      store_empty |-> (!store_full && !wb_cyc))
      else $error("store_empty high with store_full or a Wishbone cycle");

endmodule

bind stbuf_top stbuf_assert stbuf_assert_i (
   .clk, .rst_n, .store_valid, .store_req, .store_full, .store_empty,
   .wb_cyc, .wb_stb, .wb_ack, .wb_adr, .wb_dat_o, .wb_sel
);

`default_nettype wire

/* tests/stbuf_tb.sv */
//------------------------------------------------
// store buffer testbench
// clock, reset, Wishbone slave model with random
// ack delay, stimulus table, checks and timeout
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module stbuf_tb
   import stbuf_pkg::*;
();

   typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_DRAIN, OP_FULL} op_e;

   // full rows expect {empty, full} in exp_be
   // drain rows expect the write total in exp_data
   typedef struct packed {
      op_e               op;
      logic [ADDR_W-1:0] addr;
      size_e             size;
      logic [DATA_W-1:0] data;
      logic              stall;
      logic [BYTE_W-1:0] exp_be;
      logic [DATA_W-1:0] exp_data;
   } row_t;

   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [BYTE_W-1:0] sel;
      logic [DATA_W-1:0] dat;
   } wr_t;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              store_valid;
   store_req_t        store_req;
   logic              store_full;
   logic              store_empty;
   waddr_t            load_addr;
   fwd_rsp_t          fwd;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ADDR_W-1:0] wb_adr;
   logic [DATA_W-1:0] wb_dat_o;
   logic [BYTE_W-1:0] wb_sel;
   logic              wb_ack = 1'b0;

   row_t rows [$];
   wr_t  wr_exp [$];
   wr_t  wr_seen [$];                          // writes as the slave saw them
   logic slave_stall = 1'b1;
   logic in_cycle = 1'b0;
   int   ack_delay;
   int   checks;
   int   errors;
   int   cycle_cnt;
   int   timeout_cycles;
   int   wr_checked;

   always #2 clk = ~clk;                       // 4 ns period

   stbuf_top stbuf_top_i (.*);

   //------------------------------------------------
   // Wishbone slave model
   //------------------------------------------------
   always @(posedge clk) begin
      #1;
      if (wb_ack) begin
         wb_ack = 1'b0;                        // master drops cyc on this edge
         in_cycle = 1'b0;
      end else if (rst_n && wb_cyc && wb_stb && !slave_stall) begin
         if (!in_cycle) begin
            in_cycle = 1'b1;
            ack_delay = $urandom % 6;
         end
         if (ack_delay == 0) begin
            check_val("wb_we", 32'(wb_we), 32'h1);
            wr_seen.push_back('{adr: wb_adr, sel: wb_sel, dat: wb_dat_o});
            wb_ack = 1'b1;
         end else begin
            ack_delay--;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
         $display("timeout: the run was still busy after %0d cycles", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   //------------------------------------------------
   // helpers
   //------------------------------------------------
   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic check_val(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic logic [DATA_W-1:0] byte_mask(input logic [BYTE_W-1:0] sel);
      logic [DATA_W-1:0] m;
      m = '0;
      for (int b = 0; b < BYTE_W; b++) begin
         if (sel[b]) m[8*b +: 8] = 8'hff;
      end
      return m;
   endfunction

   function automatic string op_text(input op_e op);
      case (op)
         OP_STORE: return "store";
         OP_LOAD:  return "load-check";
         OP_DRAIN: return "drain-all";
         default:  return "full-check";
      endcase
   endfunction

   task automatic add_row(input op_e op, input logic [ADDR_W-1:0] addr, input size_e size,
                          input logic [DATA_W-1:0] data, input logic stall,
                          input logic [BYTE_W-1:0] exp_be, input logic [DATA_W-1:0] exp_data);
      rows.push_back('{op, addr, size, data, stall, exp_be, exp_data});
   endtask

   task automatic expect_write(input logic [ADDR_W-1:0] adr, input logic [BYTE_W-1:0] sel,
                               input logic [DATA_W-1:0] dat);
      wr_exp.push_back('{adr: adr, sel: sel, dat: dat});
   endtask

   //------------------------------------------------
   // stimulus table
   //------------------------------------------------
   task automatic build_table();
      // alignment with the slave stalled and the head held on the bus
      add_row(OP_STORE, 16'h0101, SZ_BYTE, 32'h0000_00ab, 1'b1, 4'b0000, 32'h0);
      add_row(OP_STORE, 16'h0202, SZ_HALF, 32'h0000_1234, 1'b1, 4'b0000, 32'h0);
      add_row(OP_STORE, 16'h0300, SZ_WORD, 32'hdead_beef, 1'b1, 4'b0000, 32'h0);
      add_row(OP_LOAD,  16'h0101, SZ_BYTE, 32'h0,         1'b1, 4'b0010, 32'h0000_ab00);
      add_row(OP_LOAD,  16'h0202, SZ_HALF, 32'h0,         1'b1, 4'b1100, 32'h1234_0000);
      add_row(OP_LOAD,  16'h0300, SZ_WORD, 32'h0,         1'b1, 4'b1111, 32'hdead_beef);
      // coalescing into the second entry
      add_row(OP_STORE, 16'h0200, SZ_HALF, 32'h0000_5678, 1'b1, 4'b0000, 32'h0);
      add_row(OP_STORE, 16'h0203, SZ_BYTE, 32'h0000_009a, 1'b1, 4'b0000, 32'h0);
      add_row(OP_LOAD,  16'h0200, SZ_WORD, 32'h0,         1'b1, 4'b1111, 32'h9a34_5678);
      add_row(OP_FULL,  16'h0000, SZ_WORD, 32'h0,         1'b1, 4'b0000, 32'h0);
      // head word again while on the bus so the younger entry wins
      add_row(OP_STORE, 16'h0101, SZ_BYTE, 32'h0000_0077, 1'b1, 4'b0000, 32'h0);
      add_row(OP_LOAD,  16'h0100, SZ_WORD, 32'h0,         1'b1, 4'b0010, 32'h0000_7700);
      // buffer full and a further store dropped
      add_row(OP_FULL,  16'h0400, SZ_WORD, 32'hcafe_f00d, 1'b1, 4'b0001, 32'h0);
      add_row(OP_LOAD,  16'h0400, SZ_WORD, 32'h0,         1'b1, 4'b0000, 32'h0);
      // release the slave
      add_row(OP_DRAIN, 16'h0000, SZ_WORD, 32'h0,         1'b0, 4'b0000, 32'd4);
      add_row(OP_LOAD,  16'h0101, SZ_BYTE, 32'h0,         1'b0, 4'b0000, 32'h0);
      add_row(OP_FULL,  16'h0000, SZ_WORD, 32'h0,         1'b0, 4'b0010, 32'h0);
      add_row(OP_STORE, 16'h0500, SZ_WORD, 32'h0102_0304, 1'b0, 4'b0000, 32'h0);
      add_row(OP_DRAIN, 16'h0000, SZ_WORD, 32'h0,         1'b0, 4'b0000, 32'd5);
      add_row(OP_LOAD,  16'h0500, SZ_WORD, 32'h0,         1'b0, 4'b0000, 32'h0);

      // writes in allocation order with merged bytes
      expect_write(16'h0100, 4'b0010, 32'h0000_ab00);
      expect_write(16'h0200, 4'b1111, 32'h9a34_5678);
      expect_write(16'h0300, 4'b1111, 32'hdead_beef);
      expect_write(16'h0100, 4'b0010, 32'h0000_7700);
      expect_write(16'h0500, 4'b1111, 32'h0102_0304);
   endtask

   //------------------------------------------------
   // row operations
   //------------------------------------------------
   task automatic send_store(input row_t r);
      store_req = '{addr: r.addr, size: r.size, data: r.data};
      store_valid = 1'b1;
      while (store_full) idle(1);              // hold until the buffer takes it
      idle(1);
      store_valid = 1'b0;
   endtask

   task automatic compare_forward(input row_t r);
      idle(2);
      load_addr = r.addr[ADDR_W-1:OFFS_W];
      #1;
      check_val("fwd.byteen", 32'(fwd.byteen), 32'(r.exp_be));
      check_val("fwd.data", fwd.data, r.exp_data);
      idle(1);
   endtask

   task automatic full_status(input row_t r);
      idle(2);
      check_val("store_full", 32'(store_full), 32'(r.exp_be[0]));
      check_val("store_empty", 32'(store_empty), 32'(r.exp_be[1]));
      if (r.exp_be[0]) begin
         store_req = '{addr: r.addr, size: r.size, data: r.data};
         store_valid = 1'b1;                   // must be dropped while full
         idle(1);
         store_valid = 1'b0;
         idle(2);
      end
   endtask

   task automatic drain_all(input row_t r);
      logic [DATA_W-1:0] m;
      idle(2);
      while (!store_empty || wb_cyc) idle(1);
      check_val("write count", 32'(wr_seen.size()), r.exp_data);
      for (int w = wr_checked; w < wr_seen.size() && w < wr_exp.size(); w++) begin
         m = byte_mask(wr_exp[w].sel);
         check_val("wb_adr", 32'(wr_seen[w].adr), 32'(wr_exp[w].adr));
         check_val("wb_sel", 32'(wr_seen[w].sel), 32'(wr_exp[w].sel));
         check_val("wb_dat_o", wr_seen[w].dat & m, wr_exp[w].dat & m);
      end
      wr_checked = wr_seen.size();
   endtask

   initial begin
      int errs_before;
      void'($urandom(82));
      rst_n = 1'b0;
      store_valid = 1'b0;
      store_req = '0;
      load_addr = '0;
      build_table();
      timeout_cycles = rows.size() * 40;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_val("wb_cyc after reset", 32'(wb_cyc), 32'h0);
      check_val("wb_stb after reset", 32'(wb_stb), 32'h0);
      check_val("store_full after reset", 32'(store_full), 32'h0);
      check_val("store_empty after reset", 32'(store_empty), 32'h1);

      foreach (rows[i]) begin
         errs_before = errors;
         slave_stall = rows[i].stall;
         case (rows[i].op)
            OP_STORE: send_store(rows[i]);
            OP_LOAD:  compare_forward(rows[i]);
            OP_DRAIN: drain_all(rows[i]);
            default:  full_status(rows[i]);
         endcase
         $display("row %0d %s %s", i, op_text(rows[i].op),
                  (errors == errs_before) ? "ok" : "error");
      end

      $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* store_buffer.f */
common/stbuf_pkg.sv
stbuf/stbuf_capture.sv
stbuf/stbuf_entries.sv
stbuf/stbuf_fwd.sv
stbuf/stbuf_drain.sv
source/stbuf_top.sv
tests/stbuf_assert.sv
tests/stbuf_tb.sv

/* Makefile */
# Verilator build and run for the store buffer testbench

VERILATOR ?= verilator
TOP       ?= stbuf_tb
FLIST     ?= store_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# pass only if the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
